//--- source/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

	// Payload width of one memory word
	localparam int data_bits = 64;

	// Hamming check bits at the power-of-two positions
	localparam int fec_bits = 7;

	// Data plus check bits plus the overall parity at position 0
	localparam int block_bits = data_bits + fec_bits + 1;

	// Word address width and resulting array depth
	localparam int addr_bits = 6;
	localparam int mem_depth = 1 << addr_bits;

	// Error counters saturate at their all-ones value
	localparam int count_bits = 16;

	// Plain data word as seen by the user
	typedef logic [data_bits-1:0] data_t;

	// Stored codeword in positional layout
	// Bit 0 overall parity, bits 1 2 4 .. 64 check bits, the rest data
	typedef logic [block_bits-1:0] codeword_t;

	// Word address into the array
	typedef logic [addr_bits-1:0] addr_t;

	// Error event counter value
	typedef logic [count_bits-1:0] count_t;

endpackage

`default_nettype wire

//--- source/hamming_encoder.sv
`default_nettype none

module hamming_encoder (
	input wire ecc_pkg::data_t data,
	output ecc_pkg::codeword_t codeword
);

	import ecc_pkg::*;

	// Data bits already spread over their positions
	codeword_t placed;

	// Check bits computed over the spread data
	logic [fec_bits-1:0] check;

	// Spread the data over the non power of two positions
	always_comb begin
		int pos;
		placed = '0;
		pos = 3;
		for (int i = 0; i < data_bits; i++) begin
			placed[pos] = data[i];
			// Skip the next slot if it is a check position
			pos = pos + 1;
			if ((pos & (pos - 1)) == 0)
				pos = pos + 1;
		end
	end

	// Check bit c covers every data position with bit c of its index set
	// This runs over the full block, positions 64 to 71 included
	always_comb begin
		check = '0;
		for (int c = 0; c < fec_bits; c++) begin
			for (int j = 3; j < block_bits; j++) begin
				if (((j & (1 << c)) != 0) && ((j & (j - 1)) != 0))
					check[c] = check[c] ^ placed[j];
			end
		end
	end

	// Merge the check bits in, then close with the overall parity
	always_comb begin
		codeword = placed;
		for (int c = 0; c < fec_bits; c++)
			codeword[1 << c] = check[c];
		// Even parity over the whole block
		codeword[0] = ^codeword[block_bits-1:1];
	end

endmodule

`default_nettype wire

//--- source/ecc_storage.sv
`default_nettype none

module ecc_storage (
	input wire clk,
	input wire reset,
	input wire wr_en,
	input wire ecc_pkg::addr_t wr_addr,
	input wire ecc_pkg::codeword_t wr_codeword,
	input wire ecc_pkg::codeword_t inj_mask,
	input wire rd_en,
	input wire ecc_pkg::addr_t rd_addr,
	output logic code_valid,
	output ecc_pkg::codeword_t codeword,
	output ecc_pkg::addr_t code_addr
);

	import ecc_pkg::*;

	// Codeword array, contents undefined until written
	codeword_t mem [mem_depth];

	// Word as it lands in the array
	// Set mask bits flip the matching codeword bits, zero mask stores it clean
	codeword_t stored_word;

	assign stored_word = wr_codeword ^ inj_mask;

	// Write port, same edge that samples wr_en
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= stored_word;
	end

	// Read port
	// Old contents come out on a same-address collision
	always_ff @(posedge clk) begin
		if (rd_en) begin
			codeword <= mem[rd_addr];
			// Address travels along for the error log
			code_addr <= rd_addr;
		end
	end

	// One-cycle strobe per accepted read
	always_ff @(posedge clk) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= rd_en;
	end

endmodule

`default_nettype wire

//--- source/hamming_decoder.sv
`default_nettype none

module hamming_decoder (
	input wire clk,
	input wire reset,
	input wire valid_in,
	input wire ecc_pkg::codeword_t code_in,
	output logic valid_out,
	output ecc_pkg::data_t data_out,
	output logic correctable_err,
	output logic uncorrectable_err
);

	import ecc_pkg::*;

	// Syndrome points at the flipped position, zero when clean
	logic [fec_bits-1:0] syndrome;

	// Odd number of flips anywhere in the block
	logic parity_err;

	// Syndrome lies inside the 72-bit block
	logic syn_in_range;

	// Classification of the current codeword
	logic single_flip;
	logic double_flip;

	// Codeword after the single-bit fix
	codeword_t fixed;

	// Data bits pulled back out of the fixed codeword
	data_t extracted;

	// Recompute each check over its positions, stored check bit included
	always_comb begin
		syndrome = '0;
		for (int c = 0; c < fec_bits; c++) begin
			for (int j = 1; j < block_bits; j++) begin
				if ((j & (1 << c)) != 0)
					syndrome[c] = syndrome[c] ^ code_in[j];
			end
		end
	end

	// Whole block including position 0 must XOR to zero
	assign parity_err = ^code_in;

	assign syn_in_range = int'(syndrome) < block_bits;

	// Parity error and syndrome in range means one flip
	// Zero syndrome with parity error is the parity bit itself
	assign single_flip = parity_err && syn_in_range;

	// Even flips with a nonzero syndrome cannot be located
	// An odd-weight error pointing past the block is no single flip either
	assign double_flip = (!parity_err && (syndrome != '0)) ||
		(parity_err && !syn_in_range);

	// Flip the bit the syndrome names
	// Syndrome zero touches only the parity bit, which carries no data
	always_comb begin
		fixed = code_in;
		if (single_flip)
			fixed[syndrome] = ~code_in[syndrome];
	end

	// Walk the data positions in ascending order
	always_comb begin
		int pos;
		extracted = '0;
		pos = 3;
		for (int i = 0; i < data_bits; i++) begin
			extracted[i] = fixed[pos];
			// Check positions never sit next to each other from 3 on
			pos = pos + 1;
			if ((pos & (pos - 1)) == 0)
				pos = pos + 1;
		end
	end

	// Payload register, held value is harmless when valid is low
	always_ff @(posedge clk) begin
		data_out <= extracted;
	end

	// Strobe and flags, flags only pulse alongside a valid word
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			correctable_err <= 1'b0;
			uncorrectable_err <= 1'b0;
		end else begin
			valid_out <= valid_in;
			correctable_err <= valid_in && single_flip;
			uncorrectable_err <= valid_in && double_flip;
		end
	end

endmodule

`default_nettype wire

//--- source/ecc_error_log.sv
`default_nettype none

module ecc_error_log (
	input wire clk,
	input wire reset,
	input wire valid,
	input wire corrected,
	input wire uncorrectable,
	input wire ecc_pkg::addr_t addr_in,
	output ecc_pkg::count_t corr_count,
	output ecc_pkg::count_t uncorr_count,
	output ecc_pkg::addr_t last_err_addr,
	output logic err_seen
);

	import ecc_pkg::*;

	// Read address delayed past the decoder stage
	addr_t addr_q;

	// Qualified error events for this cycle
	logic corr_hit;
	logic uncorr_hit;

	// Either kind of event
	logic any_hit;

	// Lines the address up with the decoder flags
	always_ff @(posedge clk) begin
		addr_q <= addr_in;
	end

	assign corr_hit = valid && corrected;
	assign uncorr_hit = valid && uncorrectable;
	assign any_hit = corr_hit || uncorr_hit;

	// Correctable events, stuck at all ones once full
	always_ff @(posedge clk) begin
		if (reset)
			corr_count <= '0;
		else if (corr_hit && (corr_count != '1))
			corr_count <= corr_count + 1'b1;
	end

	// Uncorrectable events, same saturation
	always_ff @(posedge clk) begin
		if (reset)
			uncorr_count <= '0;
		else if (uncorr_hit && (uncorr_count != '1))
			uncorr_count <= uncorr_count + 1'b1;
	end

	// Most recent failing address and sticky seen flag
	always_ff @(posedge clk) begin
		if (reset) begin
			last_err_addr <= '0;
			err_seen <= 1'b0;
		end else if (any_hit) begin
			last_err_addr <= addr_q;
			err_seen <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/ecc_memory.sv
`default_nettype none

module ecc_memory (
	input wire clk,
	input wire reset,

	// Write side
	input wire wr_en,
	input wire ecc_pkg::addr_t wr_addr,
	input wire ecc_pkg::data_t wr_data,
	input wire ecc_pkg::codeword_t inj_mask,

	// Read request
	input wire rd_en,
	input wire ecc_pkg::addr_t rd_addr,

	// Read result, two cycles after rd_en
	output wire rd_valid,
	output wire ecc_pkg::data_t rd_data,
	output wire corrected,
	output wire uncorrectable,

	// Error log
	output wire ecc_pkg::count_t corr_count,
	output wire ecc_pkg::count_t uncorr_count,
	output wire ecc_pkg::addr_t last_err_addr,
	output wire err_seen
);

	import ecc_pkg::*;

	// Encoder to array
	codeword_t enc_codeword;

	// Array read port to decoder
	logic code_valid;
	codeword_t codeword;
	addr_t code_addr;

	// Write data encoded on the fly
	hamming_encoder u_encoder (
		.data(wr_data),
		.codeword(enc_codeword)
	);

	// Array with fault injection on the write path
	ecc_storage u_storage (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_codeword(enc_codeword),
		.inj_mask(inj_mask),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.code_valid(code_valid),
		.codeword(codeword),
		.code_addr(code_addr)
	);

	// Second read stage, correct and classify
	hamming_decoder u_decoder (
		.clk(clk),
		.reset(reset),
		.valid_in(code_valid),
		.code_in(codeword),
		.valid_out(rd_valid),
		.data_out(rd_data),
		.correctable_err(corrected),
		.uncorrectable_err(uncorrectable)
	);

	// Counts events one cycle behind the read result
	ecc_error_log u_error_log (
		.clk(clk),
		.reset(reset),
		.valid(rd_valid),
		.corrected(corrected),
		.uncorrectable(uncorrectable),
		.addr_in(code_addr),
		.corr_count(corr_count),
		.uncorr_count(uncorr_count),
		.last_err_addr(last_err_addr),
		.err_seen(err_seen)
	);

endmodule

`default_nettype wire

//--- verification/ecc_model.svh
`ifndef ECC_MODEL_SVH
`define ECC_MODEL_SVH

// Number of bits the injection mask flips
function automatic int flip_count(input ecc_pkg::codeword_t mask);
	return $countones(mask);
endfunction

// One flip anywhere is always repaired
function automatic bit is_single_flip(input ecc_pkg::codeword_t mask);
	return flip_count(mask) == 1;
endfunction

// Two flips are detected but not repaired
function automatic bit is_double_flip(input ecc_pkg::codeword_t mask);
	return flip_count(mask) == 2;
endfunction

`endif

//--- verification/ecc_memory_tb.sv
`default_nettype none

module ecc_memory_tb;

	import ecc_pkg::*;

	`include "ecc_model.svh"

	// Clean groups come first and each flip test adds a write and a read
	localparam int clean_groups = 3;
	localparam int group_words = 8;
	localparam int double_tests = 16;
	localparam int num_rows = clean_groups * group_words * 2 + block_bits * 2 +
		double_tests * 2;
	localparam int watchdog_cycles = num_rows * 4 + 50;

	logic clk;
	logic reset;
	logic wr_en;
	addr_t wr_addr;
	data_t wr_data;
	codeword_t inj_mask;
	logic rd_en;
	addr_t rd_addr;
	logic rd_valid;
	data_t rd_data;
	logic corrected;
	logic uncorrectable;
	count_t corr_count;
	count_t uncorr_count;
	addr_t last_err_addr;
	logic err_seen;

	// Stimulus and expected results with one row per cycle
	bit row_read [num_rows];
	addr_t row_addr [num_rows];
	data_t row_data [num_rows];
	codeword_t row_mask [num_rows];
	data_t row_exp_data [num_rows];
	bit row_exp_corr [num_rows];
	bit row_exp_uncorr [num_rows];
	bit row_chk_data [num_rows];
	int row_mark [num_rows];

	// Data and injected flips the array should hold per address
	data_t shadow_data [mem_depth];
	codeword_t shadow_mask [mem_depth];

	int n_rows;
	int errors;
	int tests;
	int table_corr;
	int table_uncorr;
	int exp_corr_total;
	int exp_uncorr_total;
	addr_t exp_last_addr;
	bit exp_seen;

	ecc_memory uut (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.inj_mask(inj_mask),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.corrected(corrected),
		.uncorrectable(uncorrectable),
		.corr_count(corr_count),
		.uncorr_count(uncorr_count),
		.last_err_addr(last_err_addr),
		.err_seen(err_seen)
	);

	always #50 clk = ~clk;

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input bit got, input bit exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %0b, expected %0b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// Appends a write row and updates the shadow copy
	task automatic add_write(input addr_t addr, input bit use_rand, input data_t fixed,
		input codeword_t mask);
		data_t d;
		d = use_rand ? {$urandom, $urandom} : fixed;
		row_read[n_rows] = 1'b0;
		row_addr[n_rows] = addr;
		row_data[n_rows] = d;
		row_mask[n_rows] = mask;
		row_exp_data[n_rows] = '0;
		row_exp_corr[n_rows] = 1'b0;
		row_exp_uncorr[n_rows] = 1'b0;
		row_chk_data[n_rows] = 1'b0;
		shadow_data[addr] = d;
		shadow_mask[addr] = mask;
		n_rows++;
	endtask

	// Appends a read row with results expected from the stored word and its flips
	task automatic add_read(input addr_t addr);
		row_read[n_rows] = 1'b1;
		row_addr[n_rows] = addr;
		row_data[n_rows] = '0;
		row_mask[n_rows] = '0;
		// Written word comes back whenever at most one bit flipped
		row_exp_data[n_rows] = shadow_data[addr];
		row_exp_corr[n_rows] = is_single_flip(shadow_mask[addr]);
		row_exp_uncorr[n_rows] = is_double_flip(shadow_mask[addr]);
		// Two flips leave the data undefined
		row_chk_data[n_rows] = flip_count(shadow_mask[addr]) < 2;
		if (row_exp_corr[n_rows])
			table_corr++;
		if (row_exp_uncorr[n_rows])
			table_uncorr++;
		n_rows++;
	endtask

	task automatic build_table;
		addr_t group_addr [group_words];
		codeword_t m;
		int r;
		int p1;
		int p2;
		// Clean words read back to back after each group of writes
		for (int g = 0; g < clean_groups; g++) begin
			for (int w = 0; w < group_words; w++) begin
				r = $urandom;
				group_addr[w] = r[addr_bits-1:0];
				add_write(group_addr[w], 1'b1, '0, '0);
			end
			for (int w = 0; w < group_words; w++)
				add_read(group_addr[w]);
		end
		// One flip at every codeword position
		// Odd positions carry random data
		for (int p = 0; p < block_bits; p++) begin
			m = '0;
			m[p] = 1'b1;
			add_write(addr_t'(p % mem_depth), (p % 2) == 1, '1, m);
			add_read(addr_t'(p % mem_depth));
		end
		// Two distinct flips
		for (int t = 0; t < double_tests; t++) begin
			p1 = $urandom % block_bits;
			do
				p2 = $urandom % block_bits;
			while (p2 == p1);
			m = '0;
			m[p1] = 1'b1;
			m[p2] = 1'b1;
			r = $urandom;
			add_write(r[addr_bits-1:0], 1'b1, '0, m);
			add_read(r[addr_bits-1:0]);
		end
	endtask

	// Read result two cycles after the row was driven
	task automatic check_result(input int r);
		row_mark[r] = errors;
		if (row_read[r]) begin
			if (!rd_valid) begin
				errors++;
				$display("Read of row %0d produced no rd_valid two cycles after rd_en", r);
			end else begin
				if (row_chk_data[r])
					check_data("rd_data", rd_data, row_exp_data[r]);
				check_flag("corrected", corrected, row_exp_corr[r]);
				check_flag("uncorrectable", uncorrectable, row_exp_uncorr[r]);
			end
		end else if (rd_valid) begin
			errors++;
			$display("rd_valid went high at %0t with no read behind it", $time);
		end
	endtask

	// Log state one cycle after the read result closes the test
	task automatic check_log(input int r);
		if (row_read[r]) begin
			if (row_exp_corr[r])
				exp_corr_total++;
			if (row_exp_uncorr[r])
				exp_uncorr_total++;
			if (row_exp_corr[r] || row_exp_uncorr[r]) begin
				exp_last_addr = row_addr[r];
				exp_seen = 1'b1;
			end
			check_count("corr_count", corr_count, count_t'(exp_corr_total));
			check_count("uncorr_count", uncorr_count, count_t'(exp_uncorr_total));
			check_addr("last_err_addr", last_err_addr, exp_last_addr);
			check_flag("err_seen", err_seen, exp_seen);
			tests++;
			$display("Test %0d read of address %0d %s", tests, row_addr[r],
				(errors == row_mark[r]) ? "passed" : "failed");
		end
	endtask

	initial begin
		void'($urandom(32'h069fb7fa));
		clk = 1'b0;
		reset = 1'b1;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		inj_mask = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		n_rows = 0;
		errors = 0;
		tests = 0;
		table_corr = 0;
		table_uncorr = 0;
		exp_corr_total = 0;
		exp_uncorr_total = 0;
		exp_last_addr = '0;
		exp_seen = 1'b0;
		build_table();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// Everything visible starts cleared
		check_flag("rd_valid", rd_valid, 1'b0);
		check_flag("corrected", corrected, 1'b0);
		check_flag("uncorrectable", uncorrectable, 1'b0);
		check_count("corr_count", corr_count, '0);
		check_count("uncorr_count", uncorr_count, '0);
		check_addr("last_err_addr", last_err_addr, '0);
		check_flag("err_seen", err_seen, 1'b0);
		tests++;
		$display("Test %0d reset state %s", tests, (errors == 0) ? "passed" : "failed");
		// Three idle cycles at the end drain the pipeline
		for (int i = 0; i < n_rows + 3; i++) begin
			@(posedge clk);
			if (i < n_rows) begin
				wr_en <= !row_read[i];
				rd_en <= row_read[i];
				wr_addr <= row_addr[i];
				rd_addr <= row_addr[i];
				wr_data <= row_data[i];
				inj_mask <= row_mask[i];
			end else begin
				wr_en <= 1'b0;
				rd_en <= 1'b0;
				inj_mask <= '0;
			end
			@(negedge clk);
			// Log of the older row first so error marks stay per row
			if (i >= 3)
				check_log(i - 3);
			if ((i >= 2) && (i < n_rows + 2))
				check_result(i - 2);
		end
		// Totals against what the table holds
		check_count("corr_count", corr_count, count_t'(table_corr));
		check_count("uncorr_count", uncorr_count, count_t'(table_uncorr));
		check_flag("err_seen", err_seen, 1'b1);
		$display("Tests run %0d, failed checks %0d", tests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Ends a stuck run
	initial begin
		#(watchdog_cycles * 100);
		$display("Timeout after %0d cycles, the run did not finish", watchdog_cycles);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verification
source/ecc_pkg.sv
source/hamming_encoder.sv
source/ecc_storage.sv
source/hamming_decoder.sv
source/ecc_error_log.sv
source/ecc_memory.sv
verification/ecc_memory_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= ecc_memory_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Errors found
PASS_MSG ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
